// ==== mmu_top.f ====
loong_csr_pkg.sv
mmu_pkg.sv
mmu_csr_regs.sv
tlb_array.sv
mmu_translate.sv
mmu_top.sv
tb_mmu_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
TOP       ?= tb_mmu_top
FILELIST  ?= mmu_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := ALL CHECKS PASSED

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and search $(LOG) for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(SIM): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_mmu_top.sv ====
`timescale 1ns/10ps

module tb_mmu_top;

    import loong_csr_pkg::*;
    import mmu_pkg::*;

    localparam int ENTRIES      = 16;
    localparam int PERIOD_NS    = 40;
    localparam int RESET_CYCLES = 10;
    localparam int PIPE_ENTRIES = 8;
    localparam int PIPE_REQS    = 200;
    // cycle budgets of the tests in run order with the random test sized by its loops
    localparam int TEST_CYCLES  = 10 + 20 + 40 + 30 + PIPE_ENTRIES + PIPE_REQS + 10;
    localparam int LIMIT_NS     = (RESET_CYCLES + TEST_CYCLES + 50) * PERIOD_NS;

    logic          clk;
    logic          rst_n;
    logic          csr_we;
    csr_addr_t     csr_addr;
    logic [31:0]   csr_wdata;
    logic          tlb_we;
    tlb_write_t    tlb_wr;
    logic [31:0]   va;
    mem_type_t     mem_type;
    logic          flush;
    trans_result_t trans_result;

    // shadow copies of what has been written to the DUT
    logic [31:0]   s_crmd;
    logic [9:0]    s_asid;
    logic [31:0]   s_dmw0;
    logic [31:0]   s_dmw1;
    tlb_entry_t    s_tlb [ENTRIES];
    trans_result_t exp_q;
    string         exp_name_q;

    string  test_name;
    integer seed;
    int     fail_count;
    int     test_count;
    int     failed_tests;
    int     fails_at_start;

    mmu_top #(
        .TLB_ENTRY_NUM (ENTRIES)
    ) u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .csr_we       (csr_we),
        .csr_addr     (csr_addr),
        .csr_wdata    (csr_wdata),
        .tlb_we       (tlb_we),
        .tlb_wr       (tlb_wr),
        .va           (va),
        .mem_type     (mem_type),
        .flush        (flush),
        .trans_result (trans_result)
    );

    always #(PERIOD_NS / 2) clk = ~clk;

    function automatic logic window_hit(input logic [31:0] dmw, input logic [31:0] a,
                                        input logic [1:0] plv);
        logic allowed;
        allowed = (plv == 2'd0) ? dmw[0] : ((plv == 2'd3) ? dmw[3] : 1'b0);
        return allowed && (dmw[31:29] == a[31:29]);
    endfunction

    function automatic trans_result_t expected_result(input logic [31:0] a, input mem_type_t mt);
        trans_result_t r;
        logic          found;
        logic [3:0]    idx;
        logic          huge;
        tlb_page_t     pg;
        r = '0;
        found = 1'b0;
        idx = '0;
        if (s_crmd[3]) begin
            r.valid = 1'b1;
            r.pa = a;
            r.mat = (mt == MEM_FETCH) ? s_crmd[6:5] : s_crmd[8:7];
            return r;
        end
        if (window_hit(s_dmw0, a, s_crmd[1:0])) begin
            r.valid = 1'b1;
            r.pa = {s_dmw0[27:25], a[28:0]};
            r.mat = s_dmw0[5:4];
            return r;
        end
        if (window_hit(s_dmw1, a, s_crmd[1:0])) begin
            r.valid = 1'b1;
            r.pa = {s_dmw1[27:25], a[28:0]};
            r.mat = s_dmw1[5:4];
            return r;
        end
        for (int i = 0; i < ENTRIES; i++) begin
            if (!found && s_tlb[i].key.e && (s_tlb[i].key.g || s_tlb[i].key.asid == s_asid)
                && (s_tlb[i].key.huge ? (s_tlb[i].key.vppn[18:10] == a[31:23])
                                      : (s_tlb[i].key.vppn == a[31:13]))) begin
                found = 1'b1;
                idx = 4'(i);
            end
        end
        if (!found) begin
            r.ecode = EXC_TLBR;
            return r;
        end
        huge = s_tlb[idx].key.huge;
        pg = (huge ? a[22] : a[12]) ? s_tlb[idx].page1 : s_tlb[idx].page0;
        if (!pg.v && mt == MEM_FETCH) begin
            r.ecode = EXC_PIF;
        end else if (!pg.v && mt == MEM_STORE) begin
            r.ecode = EXC_PIS;
        end else if (!pg.v) begin
            r.ecode = EXC_PIL;
        end else if (s_crmd[1:0] > pg.plv) begin
            r.ecode = EXC_PPI;
        end else if (mt == MEM_STORE && !pg.d) begin
            r.ecode = EXC_PME;
        end else begin
            r.valid = 1'b1;
            r.mat = pg.mat;
            r.pa = huge ? {pg.ppn[19:10], a[21:0]} : {pg.ppn, a[11:0]};
        end
        return r;
    endfunction

    // the request sampled at this edge sees the shadows as they stood before it
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_crmd <= 32'h0000_0008;
            s_asid <= '0;
            s_dmw0 <= '0;
            s_dmw1 <= '0;
            for (int i = 0; i < ENTRIES; i++) begin
                s_tlb[i] <= '0;
            end
            exp_q <= '0;
        end else begin
            if (flush) begin
                exp_q <= '0;
            end else begin
                exp_q <= expected_result(va, mem_type);
            end
            exp_name_q = test_name;
            if (csr_we && csr_addr == CSR_CRMD) begin
                s_crmd <= csr_wdata;
            end
            if (csr_we && csr_addr == CSR_ASID) begin
                s_asid <= csr_wdata[9:0];
            end
            if (csr_we && csr_addr == CSR_DMW0) begin
                s_dmw0 <= csr_wdata;
            end
            if (csr_we && csr_addr == CSR_DMW1) begin
                s_dmw1 <= csr_wdata;
            end
            if (tlb_we) begin
                s_tlb[tlb_wr.index[3:0]] <= tlb_wr.entry;
            end
        end
    end

    task automatic show_mismatch(input string name, input trans_result_t exp,
                                 input trans_result_t act);
        string exp_text;
        string act_text;
        exp_text = $sformatf("valid=%b pa=%h mat=%0d ecode=%0d",
                             exp.valid, exp.pa, exp.mat, exp.ecode);
        act_text = $sformatf("valid=%b pa=%h mat=%0d ecode=%0d",
                             act.valid, act.pa, act.mat, act.ecode);
        fail_count++;
        $display("Fail %s: expected %s, actual %s", name, exp_text, act_text);
    endtask

    // outputs settle after the rising edge, so the falling edge sees stable values
    result_check: assert property (@(negedge clk) disable iff (!rst_n) trans_result == exp_q)
        else show_mismatch(exp_name_q, exp_q, trans_result);

    function automatic tlb_page_t make_page(input logic [19:0] ppn, input logic [1:0] plv,
                                            input logic [1:0] mat, input logic d, input logic v);
        return '{ppn, plv, mat, d, v};
    endfunction

    function automatic tlb_entry_t make_entry(input logic huge, input logic g,
                                              input logic [9:0] asid, input logic [31:0] base,
                                              input tlb_page_t p0, input tlb_page_t p1);
        return '{'{1'b1, huge, base[31:13], g, asid}, p0, p1};
    endfunction

    function automatic tlb_page_t random_page();
        logic [31:0] r;
        r = $random(seed);
        return '{r[19:0], r[21:20], r[23:22], r[24], r[25] | r[26]};
    endfunction

    // a small vppn range makes random addresses hit often and huge entries cover them all
    function automatic tlb_entry_t random_entry();
        logic [31:0] r;
        r = $random(seed);
        return '{'{r[0] | r[1], r[4:2] == 3'd0, {15'd0, r[8:5]}, r[9], {9'd0, r[10]}},
                 random_page(), random_page()};
    endfunction

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic write_csr(input csr_addr_t addr, input logic [31:0] data);
        csr_we = 1'b1;
        csr_addr = addr;
        csr_wdata = data;
        step();
        csr_we = 1'b0;
    endtask

    task automatic write_tlb(input logic [7:0] idx, input tlb_entry_t entry);
        tlb_we = 1'b1;
        tlb_wr.index = idx;
        tlb_wr.entry = entry;
        step();
        tlb_we = 1'b0;
    endtask

    task automatic request(input logic [31:0] addr, input mem_type_t mt);
        va = addr;
        mem_type = mt;
        step();
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        fails_at_start = fail_count;
    endtask

    task automatic end_test();
        @(negedge clk);
        #1;
        test_count++;
        if (fail_count != fails_at_start) begin
            failed_tests++;
            $display("test %s: %0d mismatches", test_name, fail_count - fails_at_start);
        end else begin
            $display("test %s: ok", test_name);
        end
        step();
    endtask

    initial begin
        #(LIMIT_NS);
        $display("run timed out after %0d ns before the tests finished", LIMIT_NS);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] rnd;
        seed = 3695;
        fail_count = 0;
        test_count = 0;
        failed_tests = 0;
        test_name = "reset";
        clk = 1'b0;
        rst_n = 1'b0;
        csr_we = 1'b0;
        csr_addr = CSR_CRMD;
        csr_wdata = '0;
        tlb_we = 1'b0;
        tlb_wr = '0;
        va = '0;
        mem_type = MEM_FETCH;
        flush = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;

        begin_test("reset_direct");
        assert (trans_result == '0) else show_mismatch(test_name, '0, trans_result);
        // da set, datf 1, datm 2
        write_csr(CSR_CRMD, 32'h0000_0128);
        request(32'h1234_5678, MEM_FETCH);
        request(32'h8765_4320, MEM_LOAD);
        request(32'hfedc_ba98, MEM_STORE);
        end_test();

        begin_test("windows");
        write_csr(CSR_CRMD, 32'h0000_0010);
        // dmw0 vseg 5 pseg 1 mat 1 plv0, dmw1 vseg 5 pseg 2 mat 2 plv0 and plv3
        write_csr(CSR_DMW0, 32'ha200_0011);
        write_csr(CSR_DMW1, 32'ha400_0029);
        request(32'ha000_1234, MEM_LOAD);
        write_csr(CSR_DMW1, 32'h8400_0029);
        request(32'h8000_5678, MEM_FETCH);
        request(32'ha123_0000, MEM_STORE);
        write_csr(CSR_CRMD, 32'h0000_0013);
        request(32'ha000_1234, MEM_LOAD);
        request(32'h8000_5678, MEM_LOAD);
        end_test();

        begin_test("tlb_hits");
        write_csr(CSR_CRMD, 32'h0000_0010);
        write_tlb(8'd0, make_entry(1'b0, 1'b1, 10'd0, 32'h0123_4000,
                  make_page(20'h11111, 2'd0, 2'd1, 1'b1, 1'b1),
                  make_page(20'h22222, 2'd0, 2'd2, 1'b1, 1'b1)));
        request(32'h0123_4abc, MEM_LOAD);
        request(32'h0123_5abc, MEM_FETCH);
        write_tlb(8'd1, make_entry(1'b1, 1'b1, 10'd0, 32'h0400_0000,
                  make_page(20'h12c00, 2'd0, 2'd1, 1'b1, 1'b1),
                  make_page(20'h34c00, 2'd0, 2'd3, 1'b1, 1'b1)));
        request(32'h0412_3456, MEM_LOAD);
        request(32'h0452_3456, MEM_STORE);
        write_tlb(8'd2, make_entry(1'b0, 1'b1, 10'h3ff, 32'h0800_0000,
                  make_page(20'h0f0f0, 2'd0, 2'd1, 1'b1, 1'b1),
                  make_page(20'h0e0e0, 2'd0, 2'd1, 1'b1, 1'b1)));
        request(32'h0800_0010, MEM_LOAD);
        write_csr(CSR_ASID, 32'h0000_0005);
        request(32'h0800_1010, MEM_LOAD);
        write_tlb(8'd3, make_entry(1'b0, 1'b0, 10'h02a, 32'h0c00_0000,
                  make_page(20'h55555, 2'd0, 2'd2, 1'b1, 1'b1),
                  make_page(20'h66666, 2'd0, 2'd2, 1'b1, 1'b1)));
        // the request held during the asid write still misses and the next one hits
        va = 32'h0c00_0020;
        mem_type = MEM_LOAD;
        write_csr(CSR_ASID, 32'h0000_002a);
        request(32'h0c00_0020, MEM_LOAD);
        end_test();

        begin_test("tlb_faults");
        write_csr(CSR_ASID, 32'h0);
        write_tlb(8'd4, make_entry(1'b0, 1'b1, 10'd0, 32'h1000_0000,
                  make_page(20'h0aaaa, 2'd0, 2'd1, 1'b1, 1'b0),
                  make_page(20'h0bbbb, 2'd0, 2'd1, 1'b0, 1'b1)));
        request(32'h1c00_0000, MEM_LOAD);
        request(32'h1000_0100, MEM_FETCH);
        request(32'h1000_0100, MEM_LOAD);
        request(32'h1000_0100, MEM_STORE);
        request(32'h1000_1100, MEM_STORE);
        request(32'h1000_1100, MEM_LOAD);
        write_tlb(8'd5, make_entry(1'b0, 1'b1, 10'd0, 32'h1400_0000,
                  make_page(20'h0cccc, 2'd0, 2'd1, 1'b1, 1'b1),
                  make_page(20'h0dddd, 2'd0, 2'd1, 1'b1, 1'b1)));
        write_csr(CSR_CRMD, 32'h0000_0013);
        request(32'h1400_0200, MEM_LOAD);
        end_test();

        begin_test("pipeline_flush");
        write_csr(CSR_CRMD, 32'h0000_0010);
        for (int n = 0; n < PIPE_ENTRIES; n++) begin
            write_tlb(8'($random(seed)), random_entry());
        end
        for (int n = 0; n < PIPE_REQS; n++) begin
            rnd = $random(seed);
            flush = (rnd[2:0] == 3'd0);
            request({15'd0, rnd[19:3]}, mem_type_t'(2'(rnd[31:24] % 8'd3)));
        end
        flush = 1'b0;
        end_test();

        $display("tests run %0d, tests with mismatches %0d, mismatches %0d",
                 test_count, failed_tests, fail_count);
        if (fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== mmu_top.sv ====
`timescale 1ns/10ps

module mmu_top #(
    parameter int TLB_ENTRY_NUM = 64
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      csr_we,
    input  loong_csr_pkg::csr_addr_t  csr_addr,
    input  logic [31:0]               csr_wdata,
    input  logic                      tlb_we,
    input  mmu_pkg::tlb_write_t       tlb_wr,
    input  logic [31:0]               va,
    input  mmu_pkg::mem_type_t        mem_type,
    input  logic                      flush,
    output mmu_pkg::trans_result_t    trans_result
);

    import loong_csr_pkg::*;
    import mmu_pkg::*;

    csr_state_t csr_state;
    logic       tlb_hit;
    logic       tlb_huge;
    tlb_page_t  tlb_page;

    mmu_csr_regs u_csr_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .csr_we    (csr_we),
        .csr_addr  (csr_addr),
        .csr_wdata (csr_wdata),
        .csr_state (csr_state)
    );

    tlb_array #(
        .TLB_ENTRY_NUM (TLB_ENTRY_NUM)
    ) u_tlb (
        .clk      (clk),
        .rst_n    (rst_n),
        .tlb_we   (tlb_we),
        .tlb_wr   (tlb_wr),
        .va       (va),
        .asid     (csr_state.asid),
        .tlb_hit  (tlb_hit),
        .tlb_page (tlb_page),
        .tlb_huge (tlb_huge)
    );

    mmu_translate u_translate (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .va           (va),
        .mem_type     (mem_type),
        .csr_state    (csr_state),
        .tlb_hit      (tlb_hit),
        .tlb_huge     (tlb_huge),
        .tlb_page     (tlb_page),
        .trans_result (trans_result)
    );

endmodule

// ==== mmu_translate.sv ====
`timescale 1ns/10ps

module mmu_translate (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flush,
    input  logic [31:0]                va,
    input  mmu_pkg::mem_type_t         mem_type,
    input  loong_csr_pkg::csr_state_t  csr_state,
    input  logic                       tlb_hit,
    input  logic                       tlb_huge,
    input  mmu_pkg::tlb_page_t         tlb_page,
    output mmu_pkg::trans_result_t     trans_result
);

    import loong_csr_pkg::*;
    import mmu_pkg::*;

    logic [1:0]    cur_plv;
    logic          da_mode;
    logic          dmw0_hit;
    logic          dmw1_hit;
    logic [31:0]   tlb_pa;
    exc_code_t     tlb_ecode;
    trans_result_t result_d;

    // only plv 0 and plv 3 have enable bits, so plv 1 and 2 never use a window
    function automatic logic dmw_match(
        input logic [31:0] dmw,
        input logic [31:0] addr,
        input logic [1:0]  plv
    );
        logic plv_ok;
        plv_ok = ((plv == 2'd0) && dmw[DMW_PLV0]) || ((plv == 2'd3) && dmw[DMW_PLV3]);
        return plv_ok && (dmw[DMW_VSEG_HI:DMW_VSEG_LO] == addr[31:29]);
    endfunction

    function automatic exc_code_t invalid_code(input mem_type_t mt);
        exc_code_t code;
        case (mt)
            MEM_FETCH: code = EXC_PIF;
            MEM_STORE: code = EXC_PIS;
            default:   code = EXC_PIL;
        endcase
        return code;
    endfunction

    assign cur_plv  = csr_state.crmd[CRMD_PLV_HI:CRMD_PLV_LO];
    assign da_mode  = csr_state.crmd[CRMD_DA];
    assign dmw0_hit = dmw_match(csr_state.dmw0, va, cur_plv);
    assign dmw1_hit = dmw_match(csr_state.dmw1, va, cur_plv);

    assign tlb_pa = tlb_huge ? {tlb_page.ppn[19:10], va[21:0]} : {tlb_page.ppn, va[11:0]};

    // the first failing check decides the exception code
    always_comb begin
        if (!tlb_hit) begin
            tlb_ecode = EXC_TLBR;
        end else if (!tlb_page.v) begin
            tlb_ecode = invalid_code(mem_type);
        end else if (cur_plv > tlb_page.plv) begin
            tlb_ecode = EXC_PPI;
        end else if ((mem_type == MEM_STORE) && !tlb_page.d) begin
            tlb_ecode = EXC_PME;
        end else begin
            tlb_ecode = EXC_NONE;
        end
    end

    always_comb begin
        result_d = '0;
        if (da_mode) begin
            result_d.valid = 1'b1;
            result_d.pa    = va;
            if (mem_type == MEM_FETCH) begin
                result_d.mat = csr_state.crmd[CRMD_DATF_HI:CRMD_DATF_LO];
            end else begin
                result_d.mat = csr_state.crmd[CRMD_DATM_HI:CRMD_DATM_LO];
            end
        end else if (dmw0_hit) begin
            result_d.valid = 1'b1;
            result_d.pa    = {csr_state.dmw0[DMW_PSEG_HI:DMW_PSEG_LO], va[28:0]};
            result_d.mat   = csr_state.dmw0[DMW_MAT_HI:DMW_MAT_LO];
        end else if (dmw1_hit) begin
            result_d.valid = 1'b1;
            result_d.pa    = {csr_state.dmw1[DMW_PSEG_HI:DMW_PSEG_LO], va[28:0]};
            result_d.mat   = csr_state.dmw1[DMW_MAT_HI:DMW_MAT_LO];
        end else if (tlb_ecode == EXC_NONE) begin
            result_d.valid = 1'b1;
            result_d.pa    = tlb_pa;
            result_d.mat   = tlb_page.mat;
        end else begin
            // a faulting access reports only its exception code
            result_d.ecode = tlb_ecode;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            trans_result <= '0;
        end else if (flush) begin
            trans_result <= '0;
        end else begin
            trans_result <= result_d;
        end
    end

endmodule

// ==== tlb_array.sv ====
`timescale 1ns/10ps

module tlb_array #(
    parameter int TLB_ENTRY_NUM = 64
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  tlb_we,
    input  mmu_pkg::tlb_write_t   tlb_wr,
    input  logic [31:0]           va,
    input  logic [9:0]            asid,
    output logic                  tlb_hit,
    output mmu_pkg::tlb_page_t    tlb_page,
    output logic                  tlb_huge
);

    import mmu_pkg::*;

    localparam int IDX_W = $clog2(TLB_ENTRY_NUM);

    logic [TLB_ENTRY_NUM-1:0] entry_e;
    tlb_entry_t               entry_q [TLB_ENTRY_NUM];
    logic [IDX_W-1:0]         wr_idx;
    logic [TLB_ENTRY_NUM-1:0] match;
    logic [IDX_W-1:0]         hit_idx;
    tlb_entry_t               hit_entry;
    logic                     odd_page;

    function automatic logic vppn_match(input tlb_key_t key, input logic [31:0] addr);
        logic eq;
        if (key.huge) begin
            eq = (key.vppn[18:10] == addr[31:23]);
        end else begin
            eq = (key.vppn == addr[31:13]);
        end
        return eq;
    endfunction

    // index bits above the array size are ignored
    assign wr_idx = tlb_wr.index[IDX_W-1:0];

    // an entry takes part in lookups only while its exist bit is set
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_e <= '0;
        end else if (tlb_we) begin
            entry_e[wr_idx] <= tlb_wr.entry.key.e;
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_we) begin
            entry_q[wr_idx] <= tlb_wr.entry;
        end
    end

    always_comb begin
        for (int i = 0; i < TLB_ENTRY_NUM; i++) begin
            match[i] = entry_e[i]
                && (entry_q[i].key.g || (entry_q[i].key.asid == asid))
                && vppn_match(entry_q[i].key, va);
        end
    end

    // scan downward so the lowest matching index is the one left standing
    always_comb begin
        hit_idx = '0;
        for (int i = TLB_ENTRY_NUM - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_idx = IDX_W'(i);
            end
        end
    end

    assign hit_entry = entry_q[hit_idx];
    assign tlb_hit   = |match;
    assign tlb_huge  = hit_entry.key.huge;

    // a 4 MB entry pairs two 4 MB pages, so va[22] picks between them
    assign odd_page = hit_entry.key.huge ? va[22] : va[12];
    assign tlb_page = odd_page ? hit_entry.page1 : hit_entry.page0;

endmodule

// ==== mmu_csr_regs.sv ====
`timescale 1ns/10ps

module mmu_csr_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     csr_we,
    input  loong_csr_pkg::csr_addr_t csr_addr,
    input  logic [31:0]              csr_wdata,
    output loong_csr_pkg::csr_state_t csr_state
);

    import loong_csr_pkg::*;

    logic [31:0]       crmd_q;
    logic [ASID_W-1:0] asid_q;
    logic [31:0]       dmw0_q;
    logic [31:0]       dmw1_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crmd_q <= CRMD_RESET;
            asid_q <= '0;
            dmw0_q <= '0;
            dmw1_q <= '0;
        end else if (csr_we) begin
            case (csr_addr)
                CSR_CRMD: begin
                    crmd_q <= csr_wdata;
                end
                CSR_ASID: begin
                    // only the asid field exists in this register
                    asid_q <= csr_wdata[ASID_W-1:0];
                end
                CSR_DMW0: begin
                    dmw0_q <= csr_wdata;
                end
                CSR_DMW1: begin
                    dmw1_q <= csr_wdata;
                end
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        csr_state.crmd = crmd_q;
        csr_state.asid = asid_q;
        csr_state.dmw0 = dmw0_q;
        csr_state.dmw1 = dmw1_q;
    end

endmodule

// ==== mmu_pkg.sv ====
package mmu_pkg;

    typedef enum logic [1:0] {
        MEM_FETCH = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_type_t;

    // EXC_NONE must stay zero so that a cleared result reads as no exception
    typedef enum logic [2:0] {
        EXC_NONE = 3'd0,
        EXC_TLBR = 3'd1,
        EXC_PIF  = 3'd2,
        EXC_PIL  = 3'd3,
        EXC_PIS  = 3'd4,
        EXC_PPI  = 3'd5,
        EXC_PME  = 3'd6
    } exc_code_t;

    // huge marks a 4 MB page, in which case only vppn[18:10] is compared
    typedef struct packed {
        logic        e;
        logic        huge;
        logic [18:0] vppn;
        logic        g;
        logic [9:0]  asid;
    } tlb_key_t;

    typedef struct packed {
        logic [19:0] ppn;
        logic [1:0]  plv;
        logic [1:0]  mat;
        logic        d;
        logic        v;
    } tlb_page_t;

    // page0 maps the even page, page1 the odd one
    typedef struct packed {
        tlb_key_t  key;
        tlb_page_t page0;
        tlb_page_t page1;
    } tlb_entry_t;

    typedef struct packed {
        logic [7:0] index;
        tlb_entry_t entry;
    } tlb_write_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pa;
        logic [1:0]  mat;
        exc_code_t   ecode;
    } trans_result_t;

endpackage

// ==== loong_csr_pkg.sv ====
package loong_csr_pkg;

    // current mode information register
    localparam int CRMD_PLV_LO  = 0;
    localparam int CRMD_PLV_HI  = 1;
    localparam int CRMD_DA      = 3;
    localparam int CRMD_PG      = 4;
    localparam int CRMD_DATF_LO = 5;
    localparam int CRMD_DATF_HI = 6;
    localparam int CRMD_DATM_LO = 7;
    localparam int CRMD_DATM_HI = 8;

    // out of reset the core runs in direct address mode with plv 0
    localparam logic [31:0] CRMD_RESET = 32'h0000_0008;

    // direct mapping window registers share one layout
    localparam int DMW_PLV0    = 0;
    localparam int DMW_PLV3    = 3;
    localparam int DMW_MAT_LO  = 4;
    localparam int DMW_MAT_HI  = 5;
    localparam int DMW_PSEG_LO = 25;
    localparam int DMW_PSEG_HI = 27;
    localparam int DMW_VSEG_LO = 29;
    localparam int DMW_VSEG_HI = 31;

    localparam int ASID_W = 10;

    // local select codes for the four registers held beside the MMU
    typedef enum logic [1:0] {
        CSR_CRMD = 2'd0,
        CSR_ASID = 2'd1,
        CSR_DMW0 = 2'd2,
        CSR_DMW1 = 2'd3
    } csr_addr_t;

    typedef struct packed {
        logic [31:0]       crmd;
        logic [ASID_W-1:0] asid;
        logic [31:0]       dmw0;
        logic [31:0]       dmw1;
    } csr_state_t;

endpackage
